/* hw/soc_bus_pkg.sv */
package soc_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // AXI response encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    TGT_SRAM = 2'd0,
    TGT_UART = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } rd_resp_t;

  typedef struct packed {
    resp_e resp;
  } wr_resp_t;

  // address map
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] UART_SIZE = 32'd8;

  // uart register offsets inside its 8 byte window
  localparam logic [2:0] UART_DATA_OFS = 3'd0;
  localparam logic [2:0] UART_STAT_OFS = 3'd4;

endpackage

/* hw/stall_lfsr.sv */
`timescale 1ns/1ps

module stall_lfsr #(
  parameter bit          STALL_EN = 1'b1,
  parameter logic [19:0] SEED     = 20'h00065
) (
  input  logic clk,
  input  logic rst_n_i,
  output logic go_o
);

  logic [19:0] state_q;

  // fibonacci form, taps at bits 19 and 18
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= SEED;
    end else begin
      state_q <= {state_q[18:0], state_q[19] ^ state_q[18]};
    end
  end

  assign go_o = STALL_EN ? state_q[19] : 1'b1;

  // all-zero state would lock the permission low forever
  a_never_zero: assert property (@(posedge clk) disable iff (!rst_n_i) state_q != '0);

endmodule

/* hw/addr_router.sv */
`timescale 1ns/1ps

module addr_router import soc_bus_pkg::*; #(
  parameter int unsigned SRAM_AW = 10
) (
  input  logic    clk,
  input  logic    rst_n_i,
  input  rd_req_t rd_req_i,
  input  logic    rd_valid_i,
  output logic    rd_ready_o,
  input  wr_req_t wr_req_i,
  input  logic    wr_valid_i,
  output logic    wr_ready_o,
  output logic    sram_rd_valid_o,
  input  logic    sram_rd_ready_i,
  output logic    uart_rd_valid_o,
  input  logic    uart_rd_ready_i,
  output logic    sram_wr_valid_o,
  input  logic    sram_wr_ready_i,
  output logic    uart_wr_valid_o,
  input  logic    uart_wr_ready_i,
  input  logic    rd_idle_i,
  input  logic    wr_idle_i,
  output logic    rd_issue_o,
  output target_e rd_tgt_o,
  output logic    wr_issue_o,
  output target_e wr_tgt_o
);

  localparam logic [ADDR_W-1:0] SRAM_SPAN = ADDR_W'(STRB_W) << SRAM_AW;

  // unsigned offsets wrap below the base, so one compare per window
  function automatic target_e decode(logic [ADDR_W-1:0] addr);
    if ((addr - SRAM_BASE) < SRAM_SPAN) begin
      return TGT_SRAM;
    end
    if ((addr - UART_BASE) < UART_SIZE) begin
      return TGT_UART;
    end
    return TGT_NONE;
  endfunction

  assign rd_tgt_o = decode(rd_req_i.addr);
  assign wr_tgt_o = decode(wr_req_i.addr);

  assign sram_rd_valid_o = rd_valid_i && rd_idle_i && (rd_tgt_o == TGT_SRAM);
  assign uart_rd_valid_o = rd_valid_i && rd_idle_i && (rd_tgt_o == TGT_UART);
  assign sram_wr_valid_o = wr_valid_i && wr_idle_i && (wr_tgt_o == TGT_SRAM);
  assign uart_wr_valid_o = wr_valid_i && wr_idle_i && (wr_tgt_o == TGT_UART);

  // unmapped requests are taken at once, merge stage answers them
  always_comb begin
    case (rd_tgt_o)
      TGT_SRAM: rd_ready_o = rd_idle_i && sram_rd_ready_i;
      TGT_UART: rd_ready_o = rd_idle_i && uart_rd_ready_i;
      default:  rd_ready_o = rd_idle_i && rd_valid_i;
    endcase
    case (wr_tgt_o)
      TGT_SRAM: wr_ready_o = wr_idle_i && sram_wr_ready_i;
      TGT_UART: wr_ready_o = wr_idle_i && uart_wr_ready_i;
      default:  wr_ready_o = wr_idle_i && wr_valid_i;
    endcase
  end

  assign rd_issue_o = rd_valid_i && rd_ready_o;
  assign wr_issue_o = wr_valid_i && wr_ready_o;

  // the merge stage must see the channel busy right after an issue
  a_rd_one_out: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_issue_o |=> !rd_idle_i);
  a_wr_one_out: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_issue_o |=> !wr_idle_i);

endmodule

/* hw/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave import soc_bus_pkg::*; #(
  parameter int unsigned SRAM_AW  = 10,
  parameter bit          STALL_EN = 1'b1,
  parameter logic [19:0] SEED     = 20'h00065
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  rd_req_t  rd_req_i,
  input  logic     rd_valid_i,
  output logic     rd_ready_o,
  output rd_resp_t rd_resp_o,
  output logic     rd_resp_valid_o,
  input  logic     rd_resp_ready_i,
  input  wr_req_t  wr_req_i,
  input  logic     wr_valid_i,
  output logic     wr_ready_o,
  output wr_resp_t wr_resp_o,
  output logic     wr_resp_valid_o,
  input  logic     wr_resp_ready_i
);

  localparam int unsigned WORD_LSB = $clog2(STRB_W);

  logic              go;
  logic              rd_fire;
  logic              wr_fire;
  logic [SRAM_AW-1:0] rd_idx;
  logic [SRAM_AW-1:0] wr_idx;
  logic [DATA_W-1:0] mem [2**SRAM_AW];

  stall_lfsr #(
    .STALL_EN (STALL_EN),
    .SEED     (SEED)
  ) u_stall (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .go_o    (go)
  );

  assign rd_idx = rd_req_i.addr[WORD_LSB +: SRAM_AW];
  assign wr_idx = wr_req_i.addr[WORD_LSB +: SRAM_AW];

  // accept only with permission and an empty response slot
  assign rd_ready_o = go && rd_valid_i && !rd_resp_valid_o;
  assign wr_ready_o = go && wr_valid_i && !wr_resp_valid_o;
  assign rd_fire    = rd_valid_i && rd_ready_o;
  assign wr_fire    = wr_valid_i && wr_ready_o;

  // writes never fail here
  assign wr_resp_o.resp = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_resp_valid_o <= 1'b0;
      wr_resp_valid_o <= 1'b0;
    end else begin
      if (rd_fire) begin
        rd_resp_valid_o <= 1'b1;
      end else if (rd_resp_ready_i) begin
        rd_resp_valid_o <= 1'b0;
      end
      if (wr_fire) begin
        wr_resp_valid_o <= 1'b1;
      end else if (wr_resp_ready_i) begin
        wr_resp_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_resp_o.data <= mem[rd_idx];
      rd_resp_o.resp <= RESP_OKAY;
    end
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_req_i.strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_req_i.data[8*b +: 8];
        end
      end
    end
  end

  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_resp_valid_o && !rd_resp_ready_i |=> rd_resp_valid_o && $stable(rd_resp_o));

endmodule

/* hw/uart_slave.sv */
`timescale 1ns/1ps

module uart_slave import soc_bus_pkg::*; #(
  parameter bit          STALL_EN = 1'b1,
  parameter logic [19:0] SEED     = 20'h3a5c1
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  rd_req_t  rd_req_i,
  input  logic     rd_valid_i,
  output logic     rd_ready_o,
  output rd_resp_t rd_resp_o,
  output logic     rd_resp_valid_o,
  input  logic     rd_resp_ready_i,
  input  wr_req_t  wr_req_i,
  input  logic     wr_valid_i,
  output logic     wr_ready_o,
  output wr_resp_t wr_resp_o,
  output logic     wr_resp_valid_o,
  input  logic     wr_resp_ready_i,
  output logic [7:0] tx_data_o,
  output logic     tx_valid_o
);

  logic       go;
  logic       rd_fire;
  logic       wr_fire;
  logic       rd_is_stat;
  logic       rd_is_data;
  logic       wr_is_data;
  logic       tx_fire;
  logic [7:0] count_q;

  stall_lfsr #(
    .STALL_EN (STALL_EN),
    .SEED     (SEED)
  ) u_stall (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .go_o    (go)
  );

  assign rd_ready_o = go && rd_valid_i && !rd_resp_valid_o;
  assign wr_ready_o = go && wr_valid_i && !wr_resp_valid_o;
  assign rd_fire    = rd_valid_i && rd_ready_o;
  assign wr_fire    = wr_valid_i && wr_ready_o;

  assign rd_is_stat = rd_req_i.addr[2:0] == UART_STAT_OFS;
  assign rd_is_data = rd_req_i.addr[2:0] == UART_DATA_OFS;
  assign wr_is_data = wr_req_i.addr[2:0] == UART_DATA_OFS;
  // only the low byte lane carries a character
  assign tx_fire    = wr_fire && wr_is_data && wr_req_i.strb[0];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_resp_valid_o <= 1'b0;
      wr_resp_valid_o <= 1'b0;
      tx_valid_o      <= 1'b0;
      count_q         <= '0;
    end else begin
      if (rd_fire) begin
        rd_resp_valid_o <= 1'b1;
      end else if (rd_resp_ready_i) begin
        rd_resp_valid_o <= 1'b0;
      end
      if (wr_fire) begin
        wr_resp_valid_o <= 1'b1;
      end else if (wr_resp_ready_i) begin
        wr_resp_valid_o <= 1'b0;
      end
      tx_valid_o <= tx_fire;
      if (tx_fire) begin
        count_q <= count_q + 8'd1;
      end
    end
  end

  // status and odd offsets are not writable
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_resp_o.data <= rd_is_stat ? DATA_W'(count_q) : '0;
      rd_resp_o.resp <= (rd_is_stat || rd_is_data) ? RESP_OKAY : RESP_SLVERR;
    end
    if (wr_fire) begin
      wr_resp_o.resp <= wr_is_data ? RESP_OKAY : RESP_SLVERR;
    end
    if (tx_fire) begin
      tx_data_o <= wr_req_i.data[7:0];
    end
  end

endmodule

/* hw/resp_merge.sv */
`timescale 1ns/1ps

module resp_merge import soc_bus_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     rd_issue_i,
  input  target_e  rd_tgt_i,
  input  logic     wr_issue_i,
  input  target_e  wr_tgt_i,
  output logic     rd_idle_o,
  output logic     wr_idle_o,
  input  rd_resp_t sram_rd_resp_i,
  input  logic     sram_rd_resp_valid_i,
  output logic     sram_rd_resp_ready_o,
  input  wr_resp_t sram_wr_resp_i,
  input  logic     sram_wr_resp_valid_i,
  output logic     sram_wr_resp_ready_o,
  input  rd_resp_t uart_rd_resp_i,
  input  logic     uart_rd_resp_valid_i,
  output logic     uart_rd_resp_ready_o,
  input  wr_resp_t uart_wr_resp_i,
  input  logic     uart_wr_resp_valid_i,
  output logic     uart_wr_resp_ready_o,
  output rd_resp_t rd_resp_o,
  output logic     rd_resp_valid_o,
  input  logic     rd_resp_ready_i,
  output wr_resp_t wr_resp_o,
  output logic     wr_resp_valid_o,
  input  logic     wr_resp_ready_i
);

  logic    rd_busy_q;
  logic    wr_busy_q;
  target_e rd_tgt_q;
  target_e wr_tgt_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_busy_q <= 1'b0;
      wr_busy_q <= 1'b0;
      rd_tgt_q  <= TGT_NONE;
      wr_tgt_q  <= TGT_NONE;
    end else begin
      if (rd_issue_i) begin
        rd_busy_q <= 1'b1;
        rd_tgt_q  <= rd_tgt_i;
      end else if (rd_resp_valid_o && rd_resp_ready_i) begin
        rd_busy_q <= 1'b0;
      end
      if (wr_issue_i) begin
        wr_busy_q <= 1'b1;
        wr_tgt_q  <= wr_tgt_i;
      end else if (wr_resp_valid_o && wr_resp_ready_i) begin
        wr_busy_q <= 1'b0;
      end
    end
  end

  assign rd_idle_o = !rd_busy_q;
  assign wr_idle_o = !wr_busy_q;

  assign sram_rd_resp_ready_o = rd_busy_q && (rd_tgt_q == TGT_SRAM) && rd_resp_ready_i;
  assign uart_rd_resp_ready_o = rd_busy_q && (rd_tgt_q == TGT_UART) && rd_resp_ready_i;
  assign sram_wr_resp_ready_o = wr_busy_q && (wr_tgt_q == TGT_SRAM) && wr_resp_ready_i;
  assign uart_wr_resp_ready_o = wr_busy_q && (wr_tgt_q == TGT_UART) && wr_resp_ready_i;

  // decode error is valid from the cycle after issue until taken
  always_comb begin
    case (rd_tgt_q)
      TGT_SRAM: begin
        rd_resp_o       = sram_rd_resp_i;
        rd_resp_valid_o = rd_busy_q && sram_rd_resp_valid_i;
      end
      TGT_UART: begin
        rd_resp_o       = uart_rd_resp_i;
        rd_resp_valid_o = rd_busy_q && uart_rd_resp_valid_i;
      end
      default: begin
        rd_resp_o       = '{data: '0, resp: RESP_DECERR};
        rd_resp_valid_o = rd_busy_q;
      end
    endcase
    case (wr_tgt_q)
      TGT_SRAM: begin
        wr_resp_o       = sram_wr_resp_i;
        wr_resp_valid_o = wr_busy_q && sram_wr_resp_valid_i;
      end
      TGT_UART: begin
        wr_resp_o       = uart_wr_resp_i;
        wr_resp_valid_o = wr_busy_q && uart_wr_resp_valid_i;
      end
      default: begin
        wr_resp_o       = '{resp: RESP_DECERR};
        wr_resp_valid_o = wr_busy_q;
      end
    endcase
  end

  property p_owned(logic vld, logic owner);
    @(posedge clk) disable iff (!rst_n_i) vld |-> owner;
  endproperty

  a_sram_rd_owned: assert property (p_owned(sram_rd_resp_valid_i,
    rd_busy_q && rd_tgt_q == TGT_SRAM));
  a_uart_rd_owned: assert property (p_owned(uart_rd_resp_valid_i,
    rd_busy_q && rd_tgt_q == TGT_UART));
  a_sram_wr_owned: assert property (p_owned(sram_wr_resp_valid_i,
    wr_busy_q && wr_tgt_q == TGT_SRAM));
  a_uart_wr_owned: assert property (p_owned(uart_wr_resp_valid_i,
    wr_busy_q && wr_tgt_q == TGT_UART));

endmodule

/* hw/soc_mem_top.sv */
`timescale 1ns/1ps

module soc_mem_top import soc_bus_pkg::*; #(
  parameter int unsigned SRAM_AW  = 10,
  parameter bit          STALL_EN = 1'b1
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  rd_req_t    rd_req_i,
  input  logic       rd_valid_i,
  output logic       rd_ready_o,
  output rd_resp_t   rd_resp_o,
  output logic       rd_resp_valid_o,
  input  logic       rd_resp_ready_i,
  input  wr_req_t    wr_req_i,
  input  logic       wr_valid_i,
  output logic       wr_ready_o,
  output wr_resp_t   wr_resp_o,
  output logic       wr_resp_valid_o,
  input  logic       wr_resp_ready_i,
  output logic [7:0] tx_data_o,
  output logic       tx_valid_o
);

  logic     sram_rd_valid, sram_rd_ready, uart_rd_valid, uart_rd_ready;
  logic     sram_wr_valid, sram_wr_ready, uart_wr_valid, uart_wr_ready;
  logic     rd_idle, wr_idle, rd_issue, wr_issue;
  target_e  rd_tgt, wr_tgt;
  rd_resp_t sram_rd_resp, uart_rd_resp;
  wr_resp_t sram_wr_resp, uart_wr_resp;
  logic     sram_rd_resp_valid, sram_rd_resp_ready, uart_rd_resp_valid, uart_rd_resp_ready;
  logic     sram_wr_resp_valid, sram_wr_resp_ready, uart_wr_resp_valid, uart_wr_resp_ready;

  addr_router #(.SRAM_AW(SRAM_AW)) u_router (
    .clk (clk), .rst_n_i (rst_n_i),
    .rd_req_i (rd_req_i), .rd_valid_i (rd_valid_i), .rd_ready_o (rd_ready_o),
    .wr_req_i (wr_req_i), .wr_valid_i (wr_valid_i), .wr_ready_o (wr_ready_o),
    .sram_rd_valid_o (sram_rd_valid), .sram_rd_ready_i (sram_rd_ready),
    .uart_rd_valid_o (uart_rd_valid), .uart_rd_ready_i (uart_rd_ready),
    .sram_wr_valid_o (sram_wr_valid), .sram_wr_ready_i (sram_wr_ready),
    .uart_wr_valid_o (uart_wr_valid), .uart_wr_ready_i (uart_wr_ready),
    .rd_idle_i (rd_idle), .wr_idle_i (wr_idle),
    .rd_issue_o (rd_issue), .rd_tgt_o (rd_tgt),
    .wr_issue_o (wr_issue), .wr_tgt_o (wr_tgt)
  );

  sram_slave #(.SRAM_AW(SRAM_AW), .STALL_EN(STALL_EN), .SEED(20'h00065)) u_sram (
    .clk (clk), .rst_n_i (rst_n_i),
    .rd_req_i (rd_req_i), .rd_valid_i (sram_rd_valid), .rd_ready_o (sram_rd_ready),
    .rd_resp_o (sram_rd_resp), .rd_resp_valid_o (sram_rd_resp_valid),
    .rd_resp_ready_i (sram_rd_resp_ready),
    .wr_req_i (wr_req_i), .wr_valid_i (sram_wr_valid), .wr_ready_o (sram_wr_ready),
    .wr_resp_o (sram_wr_resp), .wr_resp_valid_o (sram_wr_resp_valid),
    .wr_resp_ready_i (sram_wr_resp_ready)
  );

  uart_slave #(.STALL_EN(STALL_EN), .SEED(20'h3a5c1)) u_uart (
    .clk (clk), .rst_n_i (rst_n_i),
    .rd_req_i (rd_req_i), .rd_valid_i (uart_rd_valid), .rd_ready_o (uart_rd_ready),
    .rd_resp_o (uart_rd_resp), .rd_resp_valid_o (uart_rd_resp_valid),
    .rd_resp_ready_i (uart_rd_resp_ready),
    .wr_req_i (wr_req_i), .wr_valid_i (uart_wr_valid), .wr_ready_o (uart_wr_ready),
    .wr_resp_o (uart_wr_resp), .wr_resp_valid_o (uart_wr_resp_valid),
    .wr_resp_ready_i (uart_wr_resp_ready),
    .tx_data_o (tx_data_o), .tx_valid_o (tx_valid_o)
  );

  resp_merge u_merge (
    .clk (clk), .rst_n_i (rst_n_i),
    .rd_issue_i (rd_issue), .rd_tgt_i (rd_tgt),
    .wr_issue_i (wr_issue), .wr_tgt_i (wr_tgt),
    .rd_idle_o (rd_idle), .wr_idle_o (wr_idle),
    .sram_rd_resp_i (sram_rd_resp), .sram_rd_resp_valid_i (sram_rd_resp_valid),
    .sram_rd_resp_ready_o (sram_rd_resp_ready),
    .sram_wr_resp_i (sram_wr_resp), .sram_wr_resp_valid_i (sram_wr_resp_valid),
    .sram_wr_resp_ready_o (sram_wr_resp_ready),
    .uart_rd_resp_i (uart_rd_resp), .uart_rd_resp_valid_i (uart_rd_resp_valid),
    .uart_rd_resp_ready_o (uart_rd_resp_ready),
    .uart_wr_resp_i (uart_wr_resp), .uart_wr_resp_valid_i (uart_wr_resp_valid),
    .uart_wr_resp_ready_o (uart_wr_resp_ready),
    .rd_resp_o (rd_resp_o), .rd_resp_valid_o (rd_resp_valid_o),
    .rd_resp_ready_i (rd_resp_ready_i),
    .wr_resp_o (wr_resp_o), .wr_resp_valid_o (wr_resp_valid_o),
    .wr_resp_ready_i (wr_resp_ready_i)
  );

endmodule

/* bench/soc_mem_tb.sv */
`timescale 1ns/1ps

module soc_mem_tb import soc_bus_pkg::*; ();

  localparam int unsigned SRAM_AW = 10;
  localparam int N_FILL      = 32;
  localparam int N_RAND      = 24;
  localparam int N_BP        = 4;
  localparam int N_RD_STREAM = 64;
  localparam int N_WR_STREAM = 250;
  // the small uart, decode error and final status tests add about two dozen more
  localparam int N_OPS = 2 * N_FILL + N_RAND + 2 * N_BP + N_RD_STREAM + N_WR_STREAM + 24;

  logic       clk;
  logic       rst_n_i;
  rd_req_t    rd_req_i;
  logic       rd_valid_i;
  logic       rd_ready_o;
  rd_resp_t   rd_resp_o;
  logic       rd_resp_valid_o;
  logic       rd_resp_ready_i;
  wr_req_t    wr_req_i;
  logic       wr_valid_i;
  logic       wr_ready_o;
  wr_resp_t   wr_resp_o;
  logic       wr_resp_valid_o;
  logic       wr_resp_ready_i;
  logic [7:0] tx_data_o;
  logic       tx_valid_o;

  integer      seed;
  logic [31:0] shadow [2**SRAM_AW];
  logic [7:0]  exp_chars [$];
  logic [7:0]  got_chars [$];
  logic [7:0]  exp_count;

  soc_mem_top #(
    .SRAM_AW  (SRAM_AW),
    .STALL_EN (1'b1)
  ) DUT (
    .clk (clk), .rst_n_i (rst_n_i),
    .rd_req_i (rd_req_i), .rd_valid_i (rd_valid_i), .rd_ready_o (rd_ready_o),
    .rd_resp_o (rd_resp_o), .rd_resp_valid_o (rd_resp_valid_o),
    .rd_resp_ready_i (rd_resp_ready_i),
    .wr_req_i (wr_req_i), .wr_valid_i (wr_valid_i), .wr_ready_o (wr_ready_o),
    .wr_resp_o (wr_resp_o), .wr_resp_valid_o (wr_resp_valid_o),
    .wr_resp_ready_i (wr_resp_ready_i),
    .tx_data_o (tx_data_o), .tx_valid_o (tx_valid_o)
  );

  always #4 clk = ~clk;

  // expected response of one access, updates the shadow state as a side effect
  function automatic rd_resp_t ref_access(input bit wr, input logic [31:0] addr,
                                          input logic [31:0] data, input logic [3:0] strb);
    rd_resp_t    r;
    int unsigned idx;
    r.data = '0;
    r.resp = RESP_DECERR;
    if (addr >= SRAM_BASE && addr < SRAM_BASE + (32'd4 << SRAM_AW)) begin
      idx    = (addr - SRAM_BASE) >> 2;
      r.resp = RESP_OKAY;
      if (wr) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            shadow[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
      end else begin
        r.data = shadow[idx];
      end
    end else if (addr >= UART_BASE && addr < UART_BASE + 32'd8) begin
      if (wr) begin
        r.resp = (addr[2:0] == 3'd0) ? RESP_OKAY : RESP_SLVERR;
        if (addr[2:0] == 3'd0 && strb[0]) begin
          exp_chars.push_back(data[7:0]);
          exp_count = exp_count + 8'd1;
        end
      end else begin
        r.resp = RESP_OKAY;
        if (addr[2:0] == 3'd4) begin
          r.data = 32'(exp_count);
        end
      end
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic stop_on_error(input string what);
    $display("ERROR: %s", what);
    $display("** FAIL **");
    $fatal(1, "%s", what);
  endtask

  task automatic rd_wait_accept();
    do @(negedge clk); while (!rd_ready_o);
    @(posedge clk);
    rd_valid_i <= 1'b0;
  endtask

  task automatic rd_send(input logic [31:0] addr);
    @(posedge clk);
    rd_req_i   <= '{addr: addr};
    rd_valid_i <= 1'b1;
    rd_wait_accept();
  endtask

  // hold cycles keep the response ready low while the payload is watched
  task automatic rd_take(input int hold, output rd_resp_t r);
    do @(negedge clk); while (!rd_resp_valid_o);
    r = rd_resp_o;
    repeat (hold) begin
      @(negedge clk);
      check("read response held valid", 1, rd_resp_valid_o);
      check("read response held payload", r, rd_resp_o);
    end
    @(posedge clk);
    rd_resp_ready_i <= 1'b1;
    @(posedge clk);
    rd_resp_ready_i <= 1'b0;
  endtask

  task automatic wr_send(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
    @(posedge clk);
    wr_req_i   <= '{addr: addr, data: data, strb: strb};
    wr_valid_i <= 1'b1;
    do @(negedge clk); while (!wr_ready_o);
    @(posedge clk);
    wr_valid_i <= 1'b0;
  endtask

  task automatic wr_take(input int hold, output wr_resp_t r);
    do @(negedge clk); while (!wr_resp_valid_o);
    r = wr_resp_o;
    repeat (hold) begin
      @(negedge clk);
      check("write response held valid", 1, wr_resp_valid_o);
      check("write response held payload", r, wr_resp_o);
    end
    @(posedge clk);
    wr_resp_ready_i <= 1'b1;
    @(posedge clk);
    wr_resp_ready_i <= 1'b0;
  endtask

  task automatic bus_read(input string name, input logic [31:0] addr, input int hold);
    rd_resp_t exp;
    rd_resp_t got;
    exp = ref_access(1'b0, addr, '0, '0);
    rd_send(addr);
    rd_take(hold, got);
    check(name, exp, got);
  endtask

  task automatic bus_write(input string name, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb, input int hold);
    rd_resp_t exp;
    wr_resp_t got;
    exp = ref_access(1'b1, addr, data, strb);
    wr_send(addr, data, strb);
    wr_take(hold, got);
    check(name, exp.resp, got.resp);
  endtask

  // a second read waits on the bus while the first response is stalled
  task automatic blocked_read(input logic [31:0] addr, input logic [31:0] next_addr,
                              input int hold);
    rd_resp_t exp;
    rd_resp_t exp_next;
    rd_resp_t got;
    bit       taken;
    exp      = ref_access(1'b0, addr, '0, '0);
    exp_next = ref_access(1'b0, next_addr, '0, '0);
    taken    = 1'b0;
    rd_send(addr);
    fork
      begin
        rd_take(hold, got);
        taken = 1'b1;
      end
      begin
        @(posedge clk);
        rd_req_i   <= '{addr: next_addr};
        rd_valid_i <= 1'b1;
        while (!taken) begin
          @(negedge clk);
          if (rd_ready_o && !taken) begin
            stop_on_error("read accepted while the previous response was still pending");
          end
        end
      end
    join
    check("stalled read", exp, got);
    // the waiting read may already be accepted at the next edge
    while (!rd_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    rd_valid_i <= 1'b0;
    rd_take(0, got);
    check("read after stall", exp_next, got);
  endtask

  always @(negedge clk) begin
    if (rst_n_i && tx_valid_o) begin
      got_chars.push_back(tx_data_o);
    end
  end

  always @(posedge clk) begin
    while (got_chars.size() > 0) begin
      if (exp_chars.size() == 0) begin
        stop_on_error("character sent without a matching data write");
      end else begin
        check("tx character", exp_chars.pop_front(), got_chars.pop_front());
      end
    end
  end

  initial begin
    repeat (40 * N_OPS + 20) @(posedge clk);
    stop_on_error("watchdog expired, a transfer or response never completed");
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    string       msg;
    seed            = 32'h4cd8032a;
    exp_count       = '0;
    clk             = 1'b0;
    rst_n_i         = 1'b0;
    rd_req_i        = '0;
    rd_valid_i      = 1'b0;
    rd_resp_ready_i = 1'b0;
    wr_req_i        = '0;
    wr_valid_i      = 1'b0;
    wr_resp_ready_i = 1'b0;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check("reset rd_ready", 0, rd_ready_o);
    check("reset wr_ready", 0, wr_ready_o);
    check("reset rd_resp_valid", 0, rd_resp_valid_o);
    check("reset wr_resp_valid", 0, wr_resp_valid_o);
    check("reset tx_valid", 0, tx_valid_o);

    // sram fill, random strobed writes, read back
    for (int i = 0; i < N_FILL; i++) begin
      addr = SRAM_BASE + 4 * i;
      bus_write("sram fill", addr, addr * 32'h9e37_79b1, 4'hf, 0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      addr = SRAM_BASE + 4 * ($unsigned($random(seed)) % N_FILL);
      data = $random(seed);
      strb = $random(seed);
      bus_write("sram strobed write", addr, data, strb, $unsigned($random(seed)) % 4);
    end
    for (int i = 0; i < N_FILL; i++) begin
      bus_read("sram read back", SRAM_BASE + 4 * i, $unsigned($random(seed)) % 4);
    end

    // console output, every third character followed by a masked write
    msg = "hello soc";
    for (int i = 0; i < msg.len(); i++) begin
      bus_write("uart data write", UART_BASE, {24'h0, msg[i]}, 4'h1, 0);
      if (i % 3 == 2) begin
        bus_write("uart masked write", UART_BASE, 32'h21, 4'he, 0);
      end
    end

    bus_read("uart status", UART_BASE + 4, 0);
    bus_write("uart status write", UART_BASE + 4, 32'hff, 4'hf, 0);
    bus_read("uart status after write", UART_BASE + 4, 0);

    // unmapped holes, one just past the sram window
    bus_read("decode error read low", 32'h0000_1000, 0);
    bus_read("decode error read above sram", SRAM_BASE + 32'h1000, 1);
    bus_write("decode error write uart hole", UART_BASE + 8, 32'h5a, 4'h1, 0);
    bus_write("decode error write sram hole", SRAM_BASE + 32'h1000, 32'hdead_beef, 4'hf, 1);
    bus_read("sram word 0 after decode error", SRAM_BASE, 0);
    bus_read("uart status after decode error", UART_BASE + 4, 0);

    for (int k = 0; k < N_BP; k++) begin
      addr = (k % 2 == 0) ? 32'h2000_0000 : SRAM_BASE + 4 * (k + 8);
      blocked_read(SRAM_BASE + 4 * k, addr, 1 + $unsigned($random(seed)) % 6);
    end

    // sram read stream against a uart write stream, long enough to wrap the count
    fork
      for (int i = 0; i < N_RD_STREAM; i++) begin
        bus_read("overlap sram read", SRAM_BASE + 4 * ((i * 7) % N_FILL),
                 $unsigned($random(seed)) % 3);
      end
      for (int i = 0; i < N_WR_STREAM; i++) begin
        bus_write("overlap uart write", UART_BASE, 32'h20 + (i % 95), 4'h1, i % 2);
      end
    join
    bus_read("uart status after wrap", UART_BASE + 4, 0);

    repeat (4) @(posedge clk);
    check("characters still expected", 0, exp_chars.size());
    $display("** PASS **");
    $finish;
  end

endmodule

/* filelist.f */
hw/soc_bus_pkg.sv
hw/stall_lfsr.sv
hw/addr_router.sv
hw/sram_slave.sv
hw/uart_slave.sv
hw/resp_merge.sv
hw/soc_mem_top.sv
bench/soc_mem_tb.sv

/* Bender.yml */
package:
  name: soc_mem

sources:
  - files:
      - hw/soc_bus_pkg.sv
      - hw/stall_lfsr.sv
      - hw/addr_router.sv
      - hw/sram_slave.sv
      - hw/uart_slave.sv
      - hw/resp_merge.sv
      - hw/soc_mem_top.sv
  - target: test
    files:
      - bench/soc_mem_tb.sv
